//--- dv/obj_input.txt
# W addr data = CPU table write, L vpos stall = new test line (hex)
# P x value = expected non-zero pixel of that line, all others 0
W 000 20
W 001 80
W 002 30
W 004 10
W 005 60
W 006 90
W 007 50
W 009 40
W 00a 20
W 00b 08
W 00c 70
W 00e 80
W 00f a0
W 010 88
W 011 60
W 013 30
W 014 b0
W 015 84
W 016 20
W 018 50
W 019 c0
W 01a 80
W 01b 10
W 01d 70
W 01e c0
W 01f 80
W 020 40
W 022 72
L 20 0
P 014 3b
P 015 37
P 016 35
P 017 3c
P 018 38
P 019 3b
P 01a 37
P 01b 35
P 01c 39
P 01d 36
P 01e 39
P 01f 3e
L 30 1
L 70 1
P 040 54
P 042 56
P 043 5e
P 044 57
P 045 5f
P 046 53
P 047 56
P 049 57
P 04a 59
P 04b 5d
P 04c 51
P 04d 5a
P 04e 5b
P 04f 54
L 80 0
L a0 0
P 030 6e
P 031 69
P 032 66
P 033 69
P 034 65
P 035 67
P 036 6b
P 037 68
P 038 6c
P 039 65
P 03a 67
P 03b 6b
L bf 1
P 054 2b
P 055 27
P 056 25
P 057 2c
P 058 28
P 059 2b
P 05a 27
P 05b 25
P 05c 29
P 05d 26
P 05e 29
P 05f 2e
L c0 0
P 074 1b
P 075 17
P 076 4b
P 077 47
P 078 45
P 079 4c
P 07a 48
P 07b 4b
P 07c 47
P 07d 45
P 07e 49
P 07f 46
P 080 49
P 081 4e
W 024 80
W 029 80
W 02e 80
W 033 80
W 038 80
W 03d 80
W 042 80
W 047 80
W 04c 80
W 051 80
W 056 80
W 05b 80
W 060 80
W 065 80
W 06a 80
W 06f 80
W 074 80
W 079 80
W 07e 80
W 083 80
W 088 80
W 08d 80
W 092 80
W 097 80
W 09c 80
W 0a1 80
W 0a6 80
W 0ab 80
W 0b0 80
W 0b5 80
W 0ba 80
W 0bf 80
W 0c0 90
W 0c4 80
W 0c7 c8
W 0c9 80
W 0cc c8
L 00 1
P 004 9b
P 005 97
P 006 95
P 007 9c
P 008 98
P 009 9b
P 00a 97
P 00b 95
P 00c 99
P 00d 96
P 00e 99
P 00f 9e
L f0 0

//--- build.f
+incdir+design
design/obj_pkg.sv
design/obj_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buf.sv
design/obj_layer.sv
dv/obj_clk_gen.sv
dv/obj_properties.sv
dv/obj_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the sprite layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module obj_tb \
    --Mdir obj_build -o obj_sim

out=$(./obj_build/obj_sim)
echo "$out"

if grep -qx "NO ERRORS" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- dv/obj_tb.sv
//################################################
// sprite layer testbench
// stimulus and expected pixels from dv/obj_input.txt
// run from the project root
//################################################
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_tb;

    localparam int   SCAN_BUDGET = 6000;    // clks per scanned line
    localparam [7:0] BLANK_VPOS  = 8'hf0;   // no sprite visible here

    logic                   clk;
    logic                   rst;
    logic                   obj_cs;
    logic                   cpu_wrn;
    logic [`OBJ_RAM_AW-1:0] cpu_ab;
    logic [7:0]             cpu_dout;
    logic [7:0]             obj_dout;
    logic [8:0]             hpos;
    logic [7:0]             vpos;
    logic                   hbl;
    logic                   pxl_cen;
    logic [`OBJ_ROM_AW-1:0] rom_addr;
    logic [15:0]            rom_data;
    logic                   rom_ok;
    logic [7:0]             obj_pxl;
    logic [31:0]            rom_prod;

    logic        stall_en;
    logic [31:0] seed;
    logic [7:0]  exp_pxl [0:511];
    int          errors;
    int          checks;
    longint      cycles;
    longint      cycle_limit;

    obj_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    obj_layer obj_layer_i (
        .clk      (clk),
        .rst      (rst),
        .obj_cs   (obj_cs),
        .cpu_wrn  (cpu_wrn),
        .cpu_ab   (cpu_ab),
        .cpu_dout (cpu_dout),
        .obj_dout (obj_dout),
        .hpos     (hpos),
        .vpos     (vpos),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .obj_pxl  (obj_pxl)
    );

    // ROM word is the address times 0x9E37
    assign rom_prod = {14'd0, rom_addr} * 32'h0000_9e37;
    assign rom_data = rom_prod[15:0];

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rom_ok low about one cycle in four while stalling
    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            seed   = next_rand(seed);
            rom_ok = seed[17:16] != 2'b00;
        end else begin
            rom_ok = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped: cycle limit of %0d reached", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_write(input logic [8:0] a, input logic [7:0] d);
        obj_cs   = 1'b1;
        cpu_wrn  = 1'b0;
        cpu_ab   = a;
        cpu_dout = d;
        step();
        obj_cs   = 1'b0;
        cpu_wrn  = 1'b1;
    endtask

    // byte shows on obj_dout the cycle after the address
    task automatic cpu_read_check(input logic [8:0] a, input logic [7:0] d);
        obj_cs = 1'b1;
        cpu_ab = a;
        step();
        obj_cs = 1'b0;
        checks++;
        assert (obj_dout == d) else begin
            errors++;
            $display("Error: obj_dout at %h is %h, expected %h", a, obj_dout, d);
        end
    endtask

    // scan one line, swap, then read all 512 pixels back
    task automatic play_line(input logic [7:0] v, input logic stall, input logic check);
        vpos     = v;
        stall_en = stall;
        hbl      = 1'b0;             // falling edge starts the scan
        step();
        if (check) begin
            repeat (SCAN_BUDGET) step();
        end else begin
            repeat (4) step();
        end
        hbl      = 1'b1;
        stall_en = 1'b0;
        vpos     = BLANK_VPOS;       // second scan draws nothing
        repeat (2) step();
        hbl = 1'b0;                  // swap so the drawn half is read
        step();
        for (int h = 0; h < 512; h++) begin
            pxl_cen = 1'b1;
            hpos    = 9'(h);
            step();
            if (check) begin
                checks++;
                assert (obj_pxl == exp_pxl[h]) else begin
                    errors++;
                    $display("Error: obj_pxl at hpos %h is %h, expected %h",
                             9'(h), obj_pxl, exp_pxl[h]);
                end
            end
        end
        pxl_cen = 1'b0;
        hbl     = 1'b1;
        step();
    endtask

    initial begin
        int          fd;
        int          n;
        int          n_lines;
        string       text;
        logic [7:0]  cmd;
        logic [15:0] a;
        logic [15:0] b;
        logic        pending;
        logic [7:0]  line_vpos;
        logic        line_stall;

        obj_cs      = 1'b0;
        cpu_wrn     = 1'b1;
        cpu_ab      = '0;
        cpu_dout    = '0;
        hpos        = '0;
        vpos        = BLANK_VPOS;
        hbl         = 1'b1;
        pxl_cen     = 1'b0;
        rom_ok      = 1'b1;
        stall_en    = 1'b0;
        seed        = 32'ha5f7_eea3;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 64'd2000;
        pending     = 1'b0;
        line_vpos   = '0;
        line_stall  = 1'b0;
        n_lines     = 0;

        // first pass only counts test lines for the cycle limit
        fd = $fopen("dv/obj_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/obj_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    n = $sscanf(text, "%s %h %h", cmd, a, b);
                end
                if (n == 3 && cmd == "L") n_lines++;
            end
            $fclose(fd);
        end
        cycle_limit = longint'(n_lines) * 6700 + 2000;

        wait (rst == 1'b1);
        wait (rst == 1'b0);
        step();

        for (int i = 0; i < 512; i++) begin
            cpu_write(9'(i), 8'h00);
        end
        // read half is emptied once before the first test line
        play_line(BLANK_VPOS, 1'b0, 1'b0);

        fd = $fopen("dv/obj_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    n = $sscanf(text, "%s %h %h", cmd, a, b);
                end
                if (n == 3 && (cmd == "W" || cmd == "L") && pending) begin
                    play_line(line_vpos, line_stall, 1'b1);
                    pending = 1'b0;
                end
                if (n == 3 && cmd == "W") begin
                    cpu_write(a[8:0], b[7:0]);
                    cpu_read_check(a[8:0], b[7:0]);
                end else if (n == 3 && cmd == "L") begin
                    for (int h = 0; h < 512; h++) exp_pxl[h] = 8'h00;
                    line_vpos  = a[7:0];
                    line_stall = b[0];
                    pending    = 1'b1;
                end else if (n == 3 && cmd == "P") begin
                    exp_pxl[a[8:0]] = b[7:0];
                end
            end
            $fclose(fd);
            if (pending) begin
                play_line(line_vpos, line_stall, 1'b1);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- dv/obj_properties.sv
//################################################
// concurrent checks on the sprite layer
// attached to obj_layer by bind, looks into the drawer
//################################################
`timescale 1ns/1ps

module obj_properties (
    input logic        clk,
    input logic        rst,
    input logic        draw_start,
    input logic        draw_done,
    input logic        draw_busy,
    input logic        draw_fetch,
    input logic        lbuf_we,
    input logic        line_swap,
    input logic [17:0] rom_addr,
    input logic [7:0]  obj_pxl
);

    // word still pending, address must not move
    assert property (@(posedge clk) disable iff (rst)
        (draw_busy && draw_fetch && $past(draw_busy && draw_fetch)) |-> $stable(rom_addr))
        else $error("rom_addr changed while a ROM word was pending");

    assert property (@(posedge clk) disable iff (rst)
        draw_start |-> !draw_busy)
        else $error("draw_start while the drawer was busy");

    assert property (@(posedge clk)
        rst |-> (!draw_start && !draw_done && !lbuf_we && !line_swap
                 && rom_addr == '0 && obj_pxl == '0))
        else $error("control outputs not cleared during reset");

endmodule

bind obj_layer obj_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .draw_start (draw_start),
    .draw_done  (draw_done),
    .draw_busy  (u_draw.busy),
    .draw_fetch (u_draw.fetch),
    .lbuf_we    (lbuf_wr.we),
    .line_swap  (line_swap),
    .rom_addr   (rom_addr),
    .obj_pxl    (obj_pxl)
);

//--- dv/obj_clk_gen.sv
//################################################
// testbench clock and reset
// 10 ns clock, reset high for two rising edges
//################################################
`timescale 1ns/1ps

module obj_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        #1 rst = 1'b1;              // edge before the first clock
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- design/obj_layer.sv
//################################################
// sprite layer top
// CPU access during a scan corrupts that line
// pixels drawn on line N show on line N+1
//################################################
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_layer (
    input  logic                   clk,
    input  logic                   rst,
    // cpu
    input  logic                   obj_cs,
    input  logic                   cpu_wrn,
    input  logic [`OBJ_RAM_AW-1:0] cpu_ab,
    input  logic [7:0]             cpu_dout,
    output logic [7:0]             obj_dout,
    // video timing
    input  logic [8:0]             hpos,
    input  logic [7:0]             vpos,
    input  logic                   hbl,
    input  logic                   pxl_cen,
    // graphics rom
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    input  logic [15:0]            rom_data,
    input  logic                   rom_ok,
    output obj_pkg::obj_pxl_t      obj_pxl
);
    import obj_pkg::*;

    logic [`OBJ_RAM_AW-1:0] scan_addr;
    logic                   line_swap;
    obj_entry_t             draw_entry;
    logic                   draw_start;
    logic                   draw_done;
    lbuf_wr_t               lbuf_wr;

    obj_ram u_ram (
        .clk       (clk),
        .obj_cs    (obj_cs),
        .cpu_wrn   (cpu_wrn),
        .cpu_ab    (cpu_ab),
        .cpu_dout  (cpu_dout),
        .scan_addr (scan_addr),
        .obj_dout  (obj_dout)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hbl        (hbl),
        .vpos       (vpos),
        .obj_dout   (obj_dout),
        .scan_addr  (scan_addr),
        .line_swap  (line_swap),
        .draw_entry (draw_entry),
        .draw_start (draw_start),
        .draw_done  (draw_done)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .draw_entry (draw_entry),
        .draw_start (draw_start),
        .draw_done  (draw_done),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .lbuf_wr    (lbuf_wr)
    );

    obj_line_buf u_line_buf (
        .clk       (clk),
        .rst       (rst),
        .line_swap (line_swap),
        .lbuf_wr   (lbuf_wr),
        .pxl_cen   (pxl_cen),
        .hpos      (hpos),
        .obj_pxl   (obj_pxl)
    );

endmodule

//--- design/obj_line_buf.sv
//################################################
// double line buffer, 2 x 512 pixels
// one half takes drawer writes, the other is read
// at hpos on pxl_cen and cleared a cycle later
//################################################
`timescale 1ns/1ps

module obj_line_buf (
    input  logic              clk,
    input  logic              rst,
    input  logic              line_swap,
    input  obj_pkg::lbuf_wr_t lbuf_wr,
    input  logic              pxl_cen,
    input  logic [8:0]        hpos,
    output obj_pkg::obj_pxl_t obj_pxl
);
    import obj_pkg::*;

    logic       sel;                  // half being written
    logic       clr_pend;
    logic       clr_half;
    logic [8:0] clr_x;
    obj_pxl_t   mem [0:1][0:511];
    logic [1:0] wen;
    logic [8:0] wa [0:1];
    obj_pxl_t   wd [0:1];

    // one write port per half, clear before drawer
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            wa[h]  = lbuf_wr.x;
            wd[h]  = lbuf_wr.pxl;
            wen[h] = lbuf_wr.we && (sel == 1'(h));
            if (clr_pend && (clr_half == 1'(h))) begin
                wen[h] = 1'b1;
                wa[h]  = clr_x;
                wd[h]  = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if (wen[h]) begin
                mem[h][wa[h]] <= wd[h];
            end
        end
        if (pxl_cen) begin
            clr_half <= ~sel;
            clr_x    <= hpos;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel      <= 1'b0;
            clr_pend <= 1'b0;
            obj_pxl  <= '0;
        end else begin
            clr_pend <= pxl_cen;
            if (line_swap) sel <= ~sel;
            if (pxl_cen) begin
                obj_pxl <= mem[~sel][hpos];   // held between pxl_cen
            end
        end
    end

endmodule

//--- design/obj_draw.sv
//################################################
// sprite row drawer, four ROM words of four pixels
// a word is taken after rom_ok is high two cycles
// in a row, rom_ok low also holds the pixel steps
// hflip reverses word order as well as pixel order
//################################################
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_draw (
    input  logic                   clk,
    input  logic                   rst,
    input  obj_pkg::obj_entry_t    draw_entry,
    input  logic                   draw_start,
    output logic                   draw_done,
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    input  logic [15:0]            rom_data,
    input  logic                   rom_ok,
    output obj_pkg::lbuf_wr_t      lbuf_wr
);
    import obj_pkg::*;

    logic                   busy;
    logic                   fetch;       // waiting on a ROM word
    logic                   ok_dly;
    logic [3:0]             pxl_cnt;
    logic [15:0]            shift;
    logic [8:0]             posx;
    logic [1:0]             grp;
    logic [1:0]             half;
    logic [7:0]             code_id;
    logic [`OBJ_ROM_AW-1:0] addr_nx;
    logic [3:0]             pxl_col;
    logic                   accept;
    logic                   step;

    // pixel k = {d[k+12], d[k+8], d[k+4], d[k]}, kept in nibble k
    function automatic logic [15:0] planar(input logic [15:0] d);
        logic [15:0] p;
        for (int k = 0; k < 4; k++) begin
            p[4*k +: 4] = {d[k+12], d[k+8], d[k+4], d[k]};
        end
        return p;
    endfunction

    assign grp     = busy ? pxl_cnt[3:2] + 2'd1 : 2'd0;   // next word to fetch
    assign half    = draw_entry.attr.hflip ? ~grp : grp;
    assign code_id = draw_entry.attr.tall ? {draw_entry.id[7:1], draw_entry.row[4]}
                                          : draw_entry.id;
    assign addr_nx = {draw_entry.bank, code_id, draw_entry.row[3:0], half};

    assign accept  = busy & fetch & rom_ok & ok_dly;
    assign step    = busy & ~fetch & rom_ok;
    assign pxl_col = draw_entry.attr.hflip ? shift[15:12] : shift[3:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            fetch     <= 1'b0;
            ok_dly    <= 1'b0;
            pxl_cnt   <= '0;
            rom_addr  <= '0;
            draw_done <= 1'b0;
            lbuf_wr   <= '0;
        end else begin
            draw_done  <= 1'b0;
            lbuf_wr.we <= 1'b0;
            if (draw_start && !busy) begin
                busy     <= 1'b1;
                fetch    <= 1'b1;
                ok_dly   <= 1'b0;
                pxl_cnt  <= '0;
                rom_addr <= addr_nx;
            end else if (busy) begin
                if (fetch) begin
                    ok_dly <= rom_ok;
                    if (accept) begin
                        fetch  <= 1'b0;
                        ok_dly <= 1'b0;
                    end
                end else if (step) begin
                    lbuf_wr.we  <= pxl_col != 4'd0;       // colour 0 is see-through
                    lbuf_wr.x   <= posx;
                    lbuf_wr.pxl <= {draw_entry.palette, pxl_col};
                    pxl_cnt     <= pxl_cnt + 4'd1;
                    if (pxl_cnt == 4'hf) begin
                        busy      <= 1'b0;
                        draw_done <= 1'b1;
                    end else if (pxl_cnt[1:0] == 2'd3) begin
                        fetch    <= 1'b1;   // word used up
                        rom_addr <= addr_nx;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (draw_start && !busy) begin
            posx <= {draw_entry.attr.x8, draw_entry.x};
        end else if (step) begin
            posx <= posx + 9'd1;   // wraps at 512
        end

        if (accept) begin
            shift <= planar(rom_data);
        end else if (step) begin
            shift <= draw_entry.attr.hflip ? shift << 4 : shift >> 4;
        end
    end

endmodule

//--- design/obj_scan.sv
//################################################
// line scanner, runs from each falling edge of hbl
// a scan still going at the next edge is dropped,
// a sprite in flight is let finish first and may
// leave pixels in the new line
//################################################
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hbl,
    input  logic [7:0]             vpos,
    input  logic [7:0]             obj_dout,
    output logic [`OBJ_RAM_AW-1:0] scan_addr,
    output logic                   line_swap,
    output obj_pkg::obj_entry_t    draw_entry,
    output logic                   draw_start,
    input  logic                   draw_done
);
    import obj_pkg::*;

    localparam int            AW   = `OBJ_RAM_AW;
    localparam int            MAXL = `OBJ_MAX_LINE;
    localparam int            CW   = $clog2(MAXL);
    localparam logic [AW-1:0] STEP = AW'(`OBJ_ENTRY_BYTES);
    localparam logic [AW-1:0] LAST = AW'(`OBJ_SCAN_LAST);

    typedef enum logic [3:0] {
        S_IDLE, S_Y, S_ATTR, S_TEST, S_ATTR2, S_ID, S_X, S_WAIT, S_DRAIN
    } state_t;

    state_t        state;
    logic          hbl_l;
    logic          fall;
    logic [AW-1:0] base;
    logic [2:0]    offset;
    logic [CW-1:0] count;
    logic [7:0]    scan_y;
    logic [7:0]    row;
    logic [4:0]    row_fix;
    obj_attr_t     attr;
    logic          visible;
    logic          table_end;

    assign fall      = hbl_l & ~hbl;
    assign line_swap = fall;

    // attr byte is on obj_dout in S_TEST
    assign attr      = obj_attr_t'(obj_dout);
    assign row       = vpos - scan_y;          // wraps mod 256
    assign visible   = attr.enable && (row[7:5] == 3'd0) && (attr.tall || !row[4]);
    assign table_end = (base + STEP) == LAST;

    always_comb begin
        row_fix = attr.tall ? row[4:0] : {1'b0, row[3:0]};
        if (attr.vflip) begin
            row_fix = attr.tall ? ~row[4:0] : {1'b0, ~row[3:0]};
        end
    end

    // byte offset presented in each state, data arrives a state later
    always_comb begin
        case (state)
            S_ATTR:  offset = 3'd1;
            S_TEST:  offset = 3'd2;
            S_ATTR2: offset = 3'd3;
            S_ID:    offset = 3'd4;
            default: offset = 3'd0;
        endcase
    end

    assign scan_addr = base + AW'(offset);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hbl_l      <= 1'b0;
            state      <= S_IDLE;
            base       <= '0;
            count      <= '0;
            draw_start <= 1'b0;
        end else begin
            hbl_l      <= hbl;
            draw_start <= 1'b0;
            if (fall) begin
                base  <= '0;
                count <= '0;
                // sprite still in the drawer, wait for it
                if ((state == S_WAIT || state == S_DRAIN) && !draw_done) begin
                    state <= S_DRAIN;
                end else begin
                    state <= S_Y;
                end
            end else begin
                case (state)
                    S_Y:     state <= S_ATTR;
                    S_ATTR:  state <= S_TEST;
                    S_TEST: begin
                        if (visible) begin
                            state <= S_ATTR2;
                        end else if (table_end) begin
                            state <= S_IDLE;
                        end else begin
                            base  <= base + STEP;
                            state <= S_Y;
                        end
                    end
                    S_ATTR2: state <= S_ID;
                    S_ID:    state <= S_X;
                    S_X: begin
                        draw_start <= 1'b1;
                        state      <= S_WAIT;
                    end
                    S_WAIT: begin
                        if (draw_done) begin
                            if (count == CW'(MAXL - 1) || table_end) begin
                                state <= S_IDLE;   // line full or table walked
                            end else begin
                                count <= count + 1'b1;
                                base  <= base + STEP;
                                state <= S_Y;
                            end
                        end
                    end
                    S_DRAIN: if (draw_done) state <= S_Y;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // entry bytes, untouched while the drawer owns draw_entry
    always_ff @(posedge clk) begin
        case (state)
            S_ATTR: scan_y <= obj_dout;
            S_TEST: begin
                draw_entry.pad  <= '0;
                draw_entry.row  <= row_fix;
                draw_entry.attr <= attr;
            end
            S_ATTR2: begin
                draw_entry.palette <= obj_dout[7:4];
                draw_entry.bank    <= obj_dout[3:0];
            end
            S_ID:    draw_entry.id <= obj_dout;
            S_X:     draw_entry.x  <= obj_dout;
            default: ;
        endcase
    end

endmodule

//--- design/obj_ram.sv
//################################################
// sprite table, one registered read port
// CPU access wins, the scanner sees the CPU byte
// while obj_cs is high
// a write cycle returns the old byte
//################################################
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_ram (
    input  logic                   clk,
    input  logic                   obj_cs,
    input  logic                   cpu_wrn,
    input  logic [`OBJ_RAM_AW-1:0] cpu_ab,
    input  logic [7:0]             cpu_dout,
    input  logic [`OBJ_RAM_AW-1:0] scan_addr,
    output logic [7:0]             obj_dout
);

    localparam int DEPTH = 1 << `OBJ_RAM_AW;

    logic [7:0]             mem [0:DEPTH-1];
    logic [`OBJ_RAM_AW-1:0] addr;
    logic                   we;

    assign addr = obj_cs ? cpu_ab : scan_addr;   // cpu over scanner
    assign we   = obj_cs & ~cpu_wrn;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= cpu_dout;
        end
        obj_dout <= mem[addr];
    end

endmodule

//--- design/obj_pkg.sv
//################################################
// types shared by the sprite layer blocks
// attr bit positions follow the board's table format
//################################################
package obj_pkg;

    // entry byte 1
    typedef struct packed {
        logic       enable;     // bit 7
        logic [1:0] spare_hi;
        logic       tall;       // 32 lines instead of 16
        logic       hflip;
        logic       vflip;
        logic       x8;         // x bit 8
        logic       spare_lo;
    } obj_attr_t;

    // line buffer pixel, colour 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;
    } obj_pxl_t;

    // sprite handed from scanner to drawer
    typedef struct packed {
        logic [2:0] pad;
        logic [4:0] row;        // already vflip corrected
        obj_attr_t  attr;
        logic [3:0] palette;    // attr2 high nibble
        logic [3:0] bank;       // attr2 low nibble
        logic [7:0] id;
        logic [7:0] x;
    } obj_entry_t;

    typedef struct packed {
        logic       we;
        logic [8:0] x;
        obj_pxl_t   pxl;
    } lbuf_wr_t;

endpackage

//--- design/obj_defines.svh
//################################################
// sizing of the sprite layer
// ROM word address is bank(4) id(8) row(4) word(2),
// so OBJ_ROM_AW must stay at 18
//################################################
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// sprite table
`define OBJ_RAM_AW       9     // 512 bytes
`define OBJ_ENTRY_BYTES  5     // y, attr, attr2, id, x
`define OBJ_SCAN_LAST    510   // one past the last entry at 505

// per line limit
`define OBJ_MAX_LINE     32

// graphics ROM, 16-bit words
`define OBJ_ROM_AW       18

`endif
